// File: bench/pe_tile_props.sv
`timescale 1ns/10ps

module pe_tile_props #(
	parameter int TILE_ID_W = 16
) (
	input logic                 clk,
	input logic                 rst_n,
	input logic [31:0]          config_addr,
	input logic [TILE_ID_W-1:0] tile_id,
	input logic                 en_sb,
	input logic                 en_cb0,
	input logic                 en_cb1,
	input logic                 en_clb,
	input logic                 pe_result
);

	logic [3:0] enables;

	assign enables = {en_sb, en_cb0, en_cb1, en_clb};

	// decoder fires at most one target per cycle
	enables_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(enables))
		else $error("decoder raised more than one enable");

	// an enable only follows a bus cycle that carried this tile's id
	enable_needs_id: assert property (@(posedge clk) disable iff (!rst_n)
		(|enables) |-> ($past(config_addr[TILE_ID_W-1:0]) == $past(tile_id)))
		else $error("decoder enable without a matching tile id");

	pe_clear_after_reset: assert property (@(posedge clk)
		!rst_n |=> !pe_result)
		else $error("logic block result not cleared by reset");

endmodule

// File: bench/pe_tile_tb.sv
`timescale 1ns/10ps

module pe_tile_tb;

	localparam int NUM_TRACKS = 4;
	localparam int TILE_ID_W  = fabric_pkg::TILE_ID_W;
	localparam int CB_SEL_W   = $clog2(NUM_TRACKS);
	localparam int TIMEOUT_NS = 80; // ten clock periods
	localparam logic [TILE_ID_W-1:0] MY_ID = 16'h0023;

	logic                  clk;
	logic                  rst_n;
	logic [31:0]           config_addr;
	logic [31:0]           config_data;
	logic [TILE_ID_W-1:0]  tile_id;
	logic [NUM_TRACKS-1:0] in_n;
	logic [NUM_TRACKS-1:0] in_e;
	logic [NUM_TRACKS-1:0] in_s;
	logic [NUM_TRACKS-1:0] in_w;
	wire  [NUM_TRACKS-1:0] out_n;
	wire  [NUM_TRACKS-1:0] out_e;
	wire  [NUM_TRACKS-1:0] out_s;
	wire  [NUM_TRACKS-1:0] out_w;

	int seed = 62853;
	bit checking;
	bit edge_timed_out;

	// reference model
	fabric_pkg::route_sel_e route_model [4*NUM_TRACKS];
	logic [CB_SEL_W-1:0]    cb0_model;
	logic [CB_SEL_W-1:0]    cb1_model;
	fabric_pkg::logic_op_e  op_model;
	logic                   pe_model;
	logic                   dec_sb;
	logic                   dec_cb0;
	logic                   dec_cb1;
	logic                   dec_clb;
	logic [31:0]            dec_word; // write seen by the decoder that applies one edge later

	pe_tile #(
		.NUM_TRACKS(NUM_TRACKS),
		.TILE_ID_W (TILE_ID_W)
	) pe_tile_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.config_addr(config_addr),
		.config_data(config_data),
		.tile_id    (tile_id),
		.in_n       (in_n),
		.in_e       (in_e),
		.in_s       (in_s),
		.in_w       (in_w),
		.out_n      (out_n),
		.out_e      (out_e),
		.out_s      (out_s),
		.out_w      (out_w)
	);

	// decoder enables and logic block result inside the tile
	bind pe_tile pe_tile_props #(.TILE_ID_W(TILE_ID_W)) props_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.config_addr(config_addr),
		.tile_id    (tile_id),
		.en_sb      (en_sb),
		.en_cb0     (en_cb0),
		.en_cb1     (en_cb1),
		.en_clb     (en_clb),
		.pe_result  (pe_result)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	function automatic logic [TILE_ID_W-1:0] wrong_id();
		logic [31:0] r;
		r = rand32();
		if (r[TILE_ID_W-1:0] == MY_ID) begin
			r[0] = ~r[0];
		end
		return r[TILE_ID_W-1:0];
	endfunction

	// route word with no FROM_PE field
	function automatic logic [31:0] side_only_word();
		logic [31:0] w;
		logic [31:0] r;
		w = rand32();
		for (int k = 0; k < 16; k++) begin
			r = rand32();
			if (w[2*k +: 2] == 2'd3) begin
				w[2*k +: 2] = r[0] ? 2'd0 : 2'd2;
			end
		end
		return w;
	endfunction

	function automatic logic [NUM_TRACKS-1:0] side_in(input int s);
		case (s)
			0:       return in_n;
			1:       return in_e;
			2:       return in_s;
			default: return in_w;
		endcase
	endfunction

	function automatic logic apply_op(input fabric_pkg::logic_op_e op, input logic a,
			input logic b);
		case (op)
			fabric_pkg::OP_AND:  return a & b;
			fabric_pkg::OP_OR:   return a | b;
			fabric_pkg::OP_XOR:  return a ^ b;
			fabric_pkg::OP_NAND: return ~(a & b);
			default:             return 1'b0;
		endcase
	endfunction

	function automatic logic [NUM_TRACKS-1:0] expected_side(input int s);
		logic [NUM_TRACKS-1:0] v;
		logic [NUM_TRACKS-1:0] src;
		for (int t = 0; t < NUM_TRACKS; t++) begin
			case (route_model[s*NUM_TRACKS + t])
				fabric_pkg::FROM_NEXT:     src = side_in((s + 1) % 4);
				fabric_pkg::FROM_OPPOSITE: src = side_in((s + 2) % 4);
				fabric_pkg::FROM_PREV:     src = side_in((s + 3) % 4);
				default:                   src = {NUM_TRACKS{pe_model}};
			endcase
			v[t] = src[t];
		end
		return v;
	endfunction

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_tracks(input string name, input logic [NUM_TRACKS-1:0] expected,
			input logic [NUM_TRACKS-1:0] actual);
		if (actual !== expected) begin
			fail_now($sformatf("mismatch %s expected 0x%h actual 0x%h", name, expected, actual));
		end
	endtask

	task automatic check_pe(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			fail_now($sformatf("mismatch %s expected 0x%h actual 0x%h", name, expected, actual));
		end
	endtask

	task automatic wait_edges(input bit rising, input int count);
		int seen;
		seen = 0;
		edge_timed_out = 1'b0;
		while (seen < count && !edge_timed_out) begin
			fork
				begin
					if (rising) begin
						@(posedge clk);
					end else begin
						@(negedge clk);
					end
				end
				begin
					#(TIMEOUT_NS);
					edge_timed_out = 1'b1;
				end
			join_any
			disable fork;
			seen++;
		end
		if (edge_timed_out) begin
			fail_now("clock edge did not arrive before the timeout");
		end
	endtask

	// runs right at the rising edge and sees only pre-edge values
	task automatic model_update();
		fabric_pkg::cfg_target_e target;
		logic                    id_ok;
		if (!rst_n) begin
			foreach (route_model[k]) begin
				route_model[k] = fabric_pkg::FROM_NEXT;
			end
			cb0_model = '0;
			cb1_model = '0;
			op_model = fabric_pkg::OP_AND;
			pe_model = 1'b0;
			{dec_sb, dec_cb0, dec_cb1, dec_clb} = 4'b0000;
			dec_word = '0;
		end else begin
			pe_model = apply_op(op_model, in_n[cb0_model], in_e[cb1_model]); // old selects
			if (dec_sb) begin
				foreach (route_model[k]) begin
					route_model[k] = fabric_pkg::route_sel_e'(dec_word[2*k +: 2]);
				end
			end
			if (dec_cb0) cb0_model = dec_word[CB_SEL_W-1:0];
			if (dec_cb1) cb1_model = dec_word[CB_SEL_W-1:0];
			if (dec_clb) op_model = fabric_pkg::logic_op_e'(dec_word[1:0]);
			target = fabric_pkg::cfg_target_e'(config_addr[31:16]);
			id_ok = (config_addr[TILE_ID_W-1:0] == tile_id);
			dec_sb = id_ok && (target == fabric_pkg::SB);
			dec_cb0 = id_ok && (target == fabric_pkg::CB0);
			dec_cb1 = id_ok && (target == fabric_pkg::CB1);
			dec_clb = id_ok && (target == fabric_pkg::CLB);
			dec_word = config_data;
		end
	endtask

	task automatic check_outputs();
		logic [NUM_TRACKS-1:0] got [4];
		string                 names [4];
		got[0] = out_n;
		got[1] = out_e;
		got[2] = out_s;
		got[3] = out_w;
		names = '{"out_n", "out_e", "out_s", "out_w"};
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < NUM_TRACKS; t++) begin
				if (route_model[s*NUM_TRACKS + t] == fabric_pkg::FROM_PE) begin
					check_pe($sformatf("%s[%0d]", names[s], t), pe_model, got[s][t]);
				end
			end
			check_tracks(names[s], expected_side(s), got[s]);
		end
	endtask

	// one clock with the model at the rise and the check just before the fall
	task automatic run_cycle();
		wait_edges(1'b1, 1);
		model_update();
		#3;
		if (checking) check_outputs();
		wait_edges(1'b0, 1);
	endtask

	task automatic drive_tracks();
		logic [31:0] r;
		r = rand32();
		in_n = r[NUM_TRACKS-1:0];
		in_e = r[2*NUM_TRACKS-1:NUM_TRACKS];
		in_s = r[3*NUM_TRACKS-1:2*NUM_TRACKS];
		in_w = r[4*NUM_TRACKS-1:3*NUM_TRACKS];
	endtask

	task automatic write_cfg(input fabric_pkg::cfg_target_e target,
			input logic [TILE_ID_W-1:0] id, input logic [31:0] data);
		config_addr = {target, id};
		config_data = data;
		drive_tracks();
		run_cycle();
	endtask

	task automatic idle_cycles(input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r = rand32();
			config_addr = {r[31:16], wrong_id()}; // idle bus never carries our id
			config_data = rand32();
			drive_tracks();
			run_cycle();
		end
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		checking = 1'b0;
		edge_timed_out = 1'b0;
		tile_id = MY_ID;
		config_addr = {16'h0000, wrong_id()};
		config_data = '0;
		drive_tracks();
		repeat (16) run_cycle();
		rst_n = 1'b1;
		checking = 1'b1;

		// after reset every side follows the next one clockwise
		idle_cycles(20);

		// reset selects and opcode as seen through FROM_PE routes
		write_cfg(fabric_pkg::SB, MY_ID, rand32() | rand32());
		idle_cycles(20);

		// routing from the three side sources
		for (int i = 0; i < 8; i++) begin
			write_cfg(fabric_pkg::SB, MY_ID, side_only_word());
			idle_cycles(25);
		end

		// connect boxes and logic op as seen through FROM_PE routes
		for (int i = 0; i < 6; i++) begin
			write_cfg(fabric_pkg::CB0, MY_ID, rand32());
			write_cfg(fabric_pkg::CB1, MY_ID, rand32());
			write_cfg(fabric_pkg::CLB, MY_ID, rand32());
			write_cfg(fabric_pkg::SB, MY_ID, rand32() | rand32());
			idle_cycles(30);
		end

		// foreign tile ids must be ignored
		for (int i = 0; i < 5; i++) begin
			write_cfg(fabric_pkg::SB, wrong_id(), rand32());
			write_cfg(fabric_pkg::CB0, wrong_id(), rand32());
			write_cfg(fabric_pkg::CB1, wrong_id(), rand32());
			write_cfg(fabric_pkg::CLB, wrong_id(), rand32());
			idle_cycles(10);
		end

		// back to back writes with two in flight
		for (int i = 0; i < 10; i++) begin
			write_cfg(fabric_pkg::SB, MY_ID, rand32() | rand32());
			write_cfg(fabric_pkg::CLB, MY_ID, rand32());
			write_cfg(fabric_pkg::SB, MY_ID, rand32() | rand32());
			write_cfg(fabric_pkg::CLB, MY_ID, rand32());
			idle_cycles(3);
		end

		$display("Everything OK");
		$finish;
	end

endmodule

// File: common/fabric_pkg.sv
package fabric_pkg;

	// width of the tile id in the low half of the config address
	localparam int unsigned TILE_ID_W = 16;

	// target code, upper half of config_addr
	typedef enum logic [15:0] {
		CLB = 16'd4,
		CB1 = 16'd5,
		CB0 = 16'd6,
		SB  = 16'd7
	} cfg_target_e;

	// one-bit operation of the logic block
	typedef enum logic [1:0] {
		OP_AND  = 2'd0,
		OP_OR   = 2'd1,
		OP_XOR  = 2'd2,
		OP_NAND = 2'd3
	} logic_op_e;

	// source of one outgoing track, sides are n=0 e=1 s=2 w=3
	typedef enum logic [1:0] {
		FROM_NEXT     = 2'd0, // side (s+1) mod 4
		FROM_OPPOSITE = 2'd1, // side (s+2) mod 4
		FROM_PREV     = 2'd2, // side (s+3) mod 4
		FROM_PE       = 2'd3  // logic block result
	} route_sel_e;

endpackage

// File: files.f
common/fabric_pkg.sv
source/config_decoder.sv
source/connect_box.sv
source/logic_block.sv
switch_box/switch_box.sv
source/pe_tile.sv
bench/pe_tile_props.sv
bench/pe_tile_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the tile testbench with Verilator and run it, exit status tells pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps \
	-f files.f --top-module pe_tile_tb -Mdir obj_dir -o pe_tile_sim \
	&& ./obj_dir/pe_tile_sim \
	|| { echo "simulation run failed"; exit 1; }

// File: source/config_decoder.sv
`timescale 1ns/10ps

module config_decoder #(
	parameter int TILE_ID_W = fabric_pkg::TILE_ID_W
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [31:0]          config_addr,
	input  logic [31:0]          config_data,
	input  logic [TILE_ID_W-1:0] tile_id,
	output logic                 en_sb,
	output logic                 en_cb0,
	output logic                 en_cb1,
	output logic                 en_clb,
	output logic [31:0]          cfg_word
);

	logic       id_match;
	logic [3:0] en_next; // {sb, cb0, cb1, clb}

	assign id_match = (config_addr[TILE_ID_W-1:0] == tile_id);

	always_comb begin
		en_next = 4'b0000;
		if (id_match) begin
			case (config_addr[31:16])
				fabric_pkg::SB:  en_next = 4'b1000;
				fabric_pkg::CB0: en_next = 4'b0100;
				fabric_pkg::CB1: en_next = 4'b0010;
				fabric_pkg::CLB: en_next = 4'b0001;
				default:         en_next = 4'b0000; // unknown target, drop it
			endcase
		end
	end

	// retime the wide bus before it fans out into the tile
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			{en_sb, en_cb0, en_cb1, en_clb} <= 4'b0000;
			cfg_word <= '0;
		end else begin
			{en_sb, en_cb0, en_cb1, en_clb} <= en_next;
			cfg_word <= config_data;
		end
	end

endmodule

// File: source/connect_box.sv
`timescale 1ns/10ps

module connect_box #(
	parameter int NUM_TRACKS = 4,
	localparam int SEL_W = $clog2(NUM_TRACKS)
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [NUM_TRACKS-1:0] tracks,
	input  logic                  config_en,
	input  logic [SEL_W-1:0]      config_sel,
	output logic                  block_in
);

	logic [SEL_W-1:0] track_sel;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			track_sel <= '0;
		end else if (config_en) begin
			track_sel <= config_sel;
		end
	end

	// operand goes straight to the logic block, no register here
	assign block_in = tracks[track_sel];

endmodule

// File: source/logic_block.sv
`timescale 1ns/10ps

module logic_block (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  op0,
	input  logic                  op1,
	input  logic                  config_en,
	input  fabric_pkg::logic_op_e config_op,
	output logic                  pe_result
);

	fabric_pkg::logic_op_e opcode;
	logic                  op_value;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			opcode <= fabric_pkg::OP_AND;
		end else if (config_en) begin
			opcode <= config_op;
		end
	end

	always_comb begin
		case (opcode)
			fabric_pkg::OP_AND:  op_value = op0 & op1;
			fabric_pkg::OP_OR:   op_value = op0 | op1;
			fabric_pkg::OP_XOR:  op_value = op0 ^ op1;
			fabric_pkg::OP_NAND: op_value = ~(op0 & op1);
			default:             op_value = 1'b0;
		endcase
	end

	// result is registered every cycle, the opcode only on a config write
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pe_result <= 1'b0;
		end else begin
			pe_result <= op_value;
		end
	end

endmodule

// File: source/pe_tile.sv
`timescale 1ns/10ps

module pe_tile #(
	parameter int NUM_TRACKS = 4,
	parameter int TILE_ID_W  = fabric_pkg::TILE_ID_W
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [31:0]           config_addr,
	input  logic [31:0]           config_data,
	input  logic [TILE_ID_W-1:0]  tile_id,
	input  logic [NUM_TRACKS-1:0] in_n,
	input  logic [NUM_TRACKS-1:0] in_e,
	input  logic [NUM_TRACKS-1:0] in_s,
	input  logic [NUM_TRACKS-1:0] in_w,
	output logic [NUM_TRACKS-1:0] out_n,
	output logic [NUM_TRACKS-1:0] out_e,
	output logic [NUM_TRACKS-1:0] out_s,
	output logic [NUM_TRACKS-1:0] out_w
);

	localparam int CB_SEL_W = $clog2(NUM_TRACKS);

	logic        en_sb;
	logic        en_cb0;
	logic        en_cb1;
	logic        en_clb;
	logic [31:0] cfg_word;
	logic        op0;
	logic        op1;
	logic        pe_result;

	config_decoder #(
		.TILE_ID_W(TILE_ID_W)
	) config_decoder (
		.clk        (clk),
		.rst_n      (rst_n),
		.config_addr(config_addr),
		.config_data(config_data),
		.tile_id    (tile_id),
		.en_sb      (en_sb),
		.en_cb0     (en_cb0),
		.en_cb1     (en_cb1),
		.en_clb     (en_clb),
		.cfg_word   (cfg_word)
	);

	// cb0 picks from the north side, cb1 from the east side
	connect_box #(
		.NUM_TRACKS(NUM_TRACKS)
	) cb0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.tracks    (in_n),
		.config_en (en_cb0),
		.config_sel(cfg_word[CB_SEL_W-1:0]),
		.block_in  (op0)
	);

	connect_box #(
		.NUM_TRACKS(NUM_TRACKS)
	) cb1 (
		.clk       (clk),
		.rst_n     (rst_n),
		.tracks    (in_e),
		.config_en (en_cb1),
		.config_sel(cfg_word[CB_SEL_W-1:0]),
		.block_in  (op1)
	);

	logic_block compute_block (
		.clk      (clk),
		.rst_n    (rst_n),
		.op0      (op0),
		.op1      (op1),
		.config_en(en_clb),
		.config_op(fabric_pkg::logic_op_e'(cfg_word[1:0])),
		.pe_result(pe_result)
	);

	switch_box #(
		.NUM_TRACKS(NUM_TRACKS)
	) sb (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_n       (in_n),
		.in_e       (in_e),
		.in_s       (in_s),
		.in_w       (in_w),
		.pe_result  (pe_result),
		.config_en  (en_sb),
		.config_word(cfg_word),
		.out_n      (out_n),
		.out_e      (out_e),
		.out_s      (out_s),
		.out_w      (out_w)
	);

endmodule

// File: switch_box/switch_box.sv
`timescale 1ns/10ps

module switch_box #(
	parameter int NUM_TRACKS = 4
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [NUM_TRACKS-1:0] in_n,
	input  logic [NUM_TRACKS-1:0] in_e,
	input  logic [NUM_TRACKS-1:0] in_s,
	input  logic [NUM_TRACKS-1:0] in_w,
	input  logic                  pe_result,
	input  logic                  config_en,
	input  logic [31:0]           config_word,
	output logic [NUM_TRACKS-1:0] out_n,
	output logic [NUM_TRACKS-1:0] out_e,
	output logic [NUM_TRACKS-1:0] out_s,
	output logic [NUM_TRACKS-1:0] out_w
);

	// side index 0 = n, 1 = e, 2 = s, 3 = w
	logic [3:0][NUM_TRACKS-1:0] side_in;
	wire  [3:0][NUM_TRACKS-1:0] side_out;

	assign side_in[0] = in_n;
	assign side_in[1] = in_e;
	assign side_in[2] = in_s;
	assign side_in[3] = in_w;

	for (genvar s = 0; s < 4; s++) begin : g_side
		for (genvar t = 0; t < NUM_TRACKS; t++) begin : g_track
			// select k = side * NUM_TRACKS + track sits at config_word[2k+1:2k]
			localparam int K = s * NUM_TRACKS + t;
			// tracks beyond the 32 bit word keep their reset route
			localparam bit IN_WORD = (2 * K + 2 <= 32);
			localparam int LSB = IN_WORD ? 2 * K : 0;

			fabric_pkg::route_sel_e route_sel;
			logic                   track_out;

			always_ff @(posedge clk) begin
				if (!rst_n) begin
					route_sel <= fabric_pkg::FROM_NEXT;
				end else if (config_en && IN_WORD) begin
					route_sel <= fabric_pkg::route_sel_e'(config_word[LSB +: 2]);
				end
			end

			always_comb begin
				case (route_sel)
					fabric_pkg::FROM_NEXT:     track_out = side_in[(s + 1) % 4][t];
					fabric_pkg::FROM_OPPOSITE: track_out = side_in[(s + 2) % 4][t];
					fabric_pkg::FROM_PREV:     track_out = side_in[(s + 3) % 4][t];
					fabric_pkg::FROM_PE:       track_out = pe_result;
					default:                   track_out = 1'b0;
				endcase
			end

			assign side_out[s][t] = track_out;
		end
	end

	// no register on the way out, routing is a pure level path
	assign out_n = side_out[0];
	assign out_e = side_out[1];
	assign out_s = side_out[2];
	assign out_w = side_out[3];

endmodule
